/* source/conv_defs.svh */
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// Width of one weight and of one pixel channel, signed
`define CONV_DATA_WIDTH 16

// Width of one output value, signed, wraps on overflow
`define CONV_ACC_WIDTH 32

// Weights per set
// 2 out x 2 in x 1 x 1
`define CONV_WEIGHT_NUM 4

// Entries in the pixel FIFO
`define CONV_PIXEL_DEPTH 8

`endif

/* source/weight_pkg.sv */
`include "conv_defs.svh"

package weight_pkg;

	////////////////////
	// Weight types
	////////////////////

	// One signed weight
	typedef logic signed [`CONV_DATA_WIDTH-1:0] weight_t;

	// Full 1x1 kernel set for 2 in / 2 out
	// Field order matches the arrival order of the weights
	typedef struct packed {
		// Output 0
		weight_t w_o0_c0;
		weight_t w_o0_c1;
		// Output 1
		weight_t w_o1_c0;
		weight_t w_o1_c1;
	} weight_set_t;

endpackage

/* source/feature_pkg.sv */
`include "conv_defs.svh"

package feature_pkg;

	////////////////////
	// Feature map types
	////////////////////

	// One input pixel, both channels packed together
	typedef struct packed {
		// Input channel 0
		logic signed [`CONV_DATA_WIDTH-1:0] ch0;
		// Input channel 1
		logic signed [`CONV_DATA_WIDTH-1:0] ch1;
	} pixel_t;

	// One output pixel, both output channels
	// Each value is a wrapped sum of two products
	typedef struct packed {
		// Output channel 0
		logic signed [`CONV_ACC_WIDTH-1:0] out0;
		// Output channel 1
		logic signed [`CONV_ACC_WIDTH-1:0] out1;
	} result_t;

endpackage

/* source/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     write,
	input  logic     read,
	input  payload_t data_in,
	output payload_t data_out,
	output logic     full,
	output logic     empty
);

	// Pointer and occupancy widths
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Storage
	payload_t mem [DEPTH];

	// Control state
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// Qualified strobes
	logic do_write;
	logic do_read;

	// Circular increment, works for any depth
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Flags come straight off the count register
	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

	// Write allowed when full only if a read frees a slot
	assign do_write = write && (!full || read);
	assign do_read  = read && !empty;

	////////////////////
	// Data path
	////////////////////

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= data_in;
		end
		// Read data shows up one cycle after the strobe
		if (do_read) begin
			data_out <= mem[rd_ptr];
		end
	end

	////////////////////
	// Pointers and count
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_read) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Producer must never overfill
	a_no_write_full: assert property (@(posedge clk) disable iff (reset)
		write |-> !full)
		else $error("sync_fifo: write while full");

	// Consumer must never underflow
	a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
		read |-> !empty)
		else $error("sync_fifo: read while empty");

endmodule

/* source/conv_1x1_weight_buffer.sv */
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_1x1_weight_buffer import weight_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    valid_in,
	input  weight_t in,
	input  logic    load_weights,
	output weight_t out_buffer_weight,
	output logic    valid_out
);

	// Input register stage
	weight_t in_reg;
	logic    in_reg_valid;

	// Weight FIFO empty flag, only watched by the check below
	logic fifo_empty;

	// Incoming weight, one cycle of delay
	always_ff @(posedge clk) begin
		in_reg <= in;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			in_reg_valid <= 1'b0;
		end else begin
			in_reg_valid <= valid_in;
		end
	end

	////////////////////
	// Weight FIFO
	////////////////////

	// One full set of weights fits
	sync_fifo #(
		.payload_t (weight_t),
		.DEPTH     (`CONV_WEIGHT_NUM)
	) weight_fifo_inst (
		.clk      (clk),
		.reset    (reset),
		.write    (in_reg_valid),
		.read     (load_weights),
		.data_in  (in_reg),
		.data_out (out_buffer_weight),
		.full     (),
		.empty    (fifo_empty)
	);

	// Sticky once the first weight has been read out
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else if (load_weights) begin
			valid_out <= 1'b1;
		end
	end

	// Engine reads only after the source has delivered its set
	a_load_not_empty: assert property (@(posedge clk) disable iff (reset)
		load_weights |-> !fifo_empty)
		else $error("weight buffer: load_weights with no weight queued");

endmodule

/* source/conv_1x1_engine.sv */
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_1x1_engine import weight_pkg::*, feature_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    start,
	output logic    load_weights,
	input  weight_t out_buffer_weight,
	input  logic    pixel_empty,
	output logic    pixel_read,
	input  pixel_t  pixel_data,
	output logic    busy,
	output logic    result_valid,
	output result_t result
);

	// Counts 0 up to the weight count
	localparam int LOAD_W = $clog2(`CONV_WEIGHT_NUM + 1);

	// Load sequencer
	logic [LOAD_W-1:0] load_count;
	logic              cap_en;
	logic [LOAD_W-1:0] cap_idx;
	logic              have_weights;

	// Kernel registers
	weight_set_t weight_set;

	// Pixel pipeline
	logic pixel_valid;

	// Products and sums, 32 bit wrap
	logic signed [`CONV_ACC_WIDTH-1:0] prod_o0_c0;
	logic signed [`CONV_ACC_WIDTH-1:0] prod_o0_c1;
	logic signed [`CONV_ACC_WIDTH-1:0] prod_o1_c0;
	logic signed [`CONV_ACC_WIDTH-1:0] prod_o1_c1;
	logic signed [`CONV_ACC_WIDTH-1:0] sum_o0;
	logic signed [`CONV_ACC_WIDTH-1:0] sum_o1;

	////////////////////
	// Weight load sequencer
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			busy         <= 1'b0;
			load_weights <= 1'b0;
			load_count   <= '0;
			cap_en       <= 1'b0;
			cap_idx      <= '0;
			have_weights <= 1'b0;
		end else begin
			// Buffer output lags each read by one cycle
			cap_en  <= load_weights;
			cap_idx <= load_count;

			// Start ignored unless idle
			if (start && !busy) begin
				busy         <= 1'b1;
				load_weights <= 1'b1;
				load_count   <= '0;
			end else if (load_weights) begin
				load_count <= load_count + 1'b1;
				// Four back-to-back reads
				if (load_count == LOAD_W'(`CONV_WEIGHT_NUM - 1)) begin
					load_weights <= 1'b0;
				end
			end

			// Last weight captured, set is complete
			if (cap_en && cap_idx == LOAD_W'(`CONV_WEIGHT_NUM - 1)) begin
				busy         <= 1'b0;
				have_weights <= 1'b1;
			end
		end
	end

	// Fill the set in arrival order
	always_ff @(posedge clk) begin
		if (cap_en) begin
			case (cap_idx)
				LOAD_W'(0): weight_set.w_o0_c0 <= out_buffer_weight;
				LOAD_W'(1): weight_set.w_o0_c1 <= out_buffer_weight;
				LOAD_W'(2): weight_set.w_o1_c0 <= out_buffer_weight;
				default:    weight_set.w_o1_c1 <= out_buffer_weight;
			endcase
		end
	end

	////////////////////
	// Pixel pop and MAC
	////////////////////

	// One pop per cycle, empty flag already tracks each pop
	assign pixel_read = !busy && have_weights && !pixel_empty;

	// FIFO data valid one cycle after the pop
	always_ff @(posedge clk) begin
		if (reset) begin
			pixel_valid  <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			pixel_valid  <= pixel_read;
			result_valid <= pixel_valid;
		end
	end

	// Signed 16x16 products, sums wrap at 32 bits
	always_comb begin
		prod_o0_c0 = weight_set.w_o0_c0 * pixel_data.ch0;
		prod_o0_c1 = weight_set.w_o0_c1 * pixel_data.ch1;
		prod_o1_c0 = weight_set.w_o1_c0 * pixel_data.ch0;
		prod_o1_c1 = weight_set.w_o1_c1 * pixel_data.ch1;
		sum_o0     = prod_o0_c0 + prod_o0_c1;
		sum_o1     = prod_o1_c0 + prod_o1_c1;
	end

	// Result registered alongside result_valid
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			result.out0 <= sum_o0;
			result.out1 <= sum_o1;
		end
	end

	// Kernel must be stable while a popped pixel is in the MAC
	a_kernel_stable: assert property (@(posedge clk) disable iff (reset)
		cap_en |-> !pixel_valid)
		else $error("engine: weight set rewritten under a pixel in flight");

endmodule

/* source/conv_1x1_top.sv */
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_1x1_top import weight_pkg::*, feature_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    weight_valid,
	input  weight_t weight_in,
	input  logic    pixel_valid,
	input  pixel_t  pixel_in,
	input  logic    start,
	output logic    weights_loaded,
	output logic    busy,
	output logic    pixel_full,
	output logic    result_valid,
	output result_t result
);

	// Weight path between buffer and engine
	logic    load_weights;
	weight_t out_buffer_weight;

	// Pixel path between FIFO and engine
	logic   pixel_read;
	pixel_t pixel_data;
	logic   pixel_empty;

	////////////////////
	// Weight staging
	////////////////////

	conv_1x1_weight_buffer weight_buffer_inst (
		.clk               (clk),
		.reset             (reset),
		.valid_in          (weight_valid),
		.in                (weight_in),
		.load_weights      (load_weights),
		.out_buffer_weight (out_buffer_weight),
		.valid_out         (weights_loaded)
	);

	// Pixel queue, full flag goes straight out to the source
	sync_fifo #(
		.payload_t (pixel_t),
		.DEPTH     (`CONV_PIXEL_DEPTH)
	) pixel_fifo_inst (
		.clk      (clk),
		.reset    (reset),
		.write    (pixel_valid),
		.read     (pixel_read),
		.data_in  (pixel_in),
		.data_out (pixel_data),
		.full     (pixel_full),
		.empty    (pixel_empty)
	);

	////////////////////
	// Compute
	////////////////////

	conv_1x1_engine engine_inst (
		.clk               (clk),
		.reset             (reset),
		.start             (start),
		.load_weights      (load_weights),
		.out_buffer_weight (out_buffer_weight),
		.pixel_empty       (pixel_empty),
		.pixel_read        (pixel_read),
		.pixel_data        (pixel_data),
		.busy              (busy),
		.result_valid      (result_valid),
		.result            (result)
	);

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic reset
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Reset held for a fixed number of rising edges
	// released on a falling edge like every other input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

/* testbench/tb_conv_1x1_top.sv */
`timescale 1ns/1ps
`include "conv_defs.svh"

module tb_conv_1x1_top import weight_pkg::*, feature_pkg::*; ();

	// Cycle limit for every wait loop
	localparam int TIMEOUT = 200;

	logic    clk;
	logic    reset;
	logic    weight_valid;
	weight_t weight_in;
	logic    pixel_valid;
	pixel_t  pixel_in;
	logic    start;
	logic    weights_loaded;
	logic    busy;
	logic    pixel_full;
	logic    result_valid;
	result_t result;

	// Reference model state
	weight_t w_model [4];
	pixel_t  pix_q [$];
	result_t got_q [$];
	logic    loaded_seen;
	int      seed;

	tb_clock_gen clock_gen_inst (.clk(clk), .reset(reset));

	conv_1x1_top conv_1x1_top_inst (.*);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// Model of one output pixel, 64 bit sums cut to 32
	function automatic result_t expected_result(input pixel_t p);
		longint  s0;
		longint  s1;
		result_t r;
		s0 = longint'(w_model[0]) * longint'(p.ch0) + longint'(w_model[1]) * longint'(p.ch1);
		s1 = longint'(w_model[2]) * longint'(p.ch0) + longint'(w_model[3]) * longint'(p.ch1);
		r.out0 = 32'(s0);
		r.out1 = 32'(s1);
		return r;
	endfunction

	////////////////////
	// Output monitor
	////////////////////

	// Outputs settle after the rising edge, sampled on the falling one
	always @(negedge clk) begin
		if (!reset) begin
			if (result_valid) begin
				got_q.push_back(result);
			end
			// Sticky once set
			assert (!loaded_seen || weights_loaded)
				else report_failure($sformatf("mismatch at %0t: weights_loaded dropped", $time));
			if (weights_loaded) begin
				loaded_seen = 1'b1;
			end
		end
	end

	task automatic wait_busy(input logic level);
		int cycles;
		cycles = 0;
		while (busy !== level) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				report_failure($sformatf("timeout waiting for busy to become %0b", level));
			end
		end
	endtask

	// One weight per strobe, arrival order matches the set fields
	task automatic write_weights(input weight_t a, input weight_t b, input weight_t c,
		input weight_t d);
		weight_t w [4];
		w = '{a, b, c, d};
		for (int i = 0; i < `CONV_WEIGHT_NUM; i++) begin
			@(negedge clk);
			weight_valid = 1'b1;
			weight_in    = w[i];
			w_model[i]   = w[i];
		end
		@(negedge clk);
		weight_valid = 1'b0;
	endtask

	task automatic load_weight_set(input weight_t a, input weight_t b, input weight_t c,
		input weight_t d);
		write_weights(a, b, c, d);
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_busy(1'b1);
		wait_busy(1'b0);
		assert (weights_loaded)
			else report_failure($sformatf("mismatch at %0t: weights_loaded low", $time));
	endtask

	// Leaves pixel_valid high so writes run back to back
	task automatic write_pixel(input pixel_t p);
		@(negedge clk);
		assert (!pixel_full) else report_failure("pixel FIFO full before a write");
		pixel_valid = 1'b1;
		pixel_in    = p;
		pix_q.push_back(p);
	endtask

	task automatic stop_pixels();
		@(negedge clk);
		pixel_valid = 1'b0;
	endtask

	// Waits for n results, then some quiet cycles, then compares in order
	task automatic check_results(input int n);
		int      cycles;
		result_t exp_r;
		result_t got_r;
		cycles = 0;
		while (got_q.size() < n) begin
			@(posedge clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				report_failure($sformatf("timeout, %0d of %0d results seen", got_q.size(), n));
			end
		end
		repeat (10) @(posedge clk);
		assert (got_q.size() == n)
			else report_failure($sformatf("mismatch at %0t: %0d results, expected %0d",
				$time, got_q.size(), n));
		for (int i = 0; i < n; i++) begin
			exp_r = expected_result(pix_q.pop_front());
			got_r = got_q.pop_front();
			assert (got_r == exp_r)
				else report_failure($sformatf("mismatch at %0t: result %0d got %0d/%0d exp %0d/%0d",
					$time, i, got_r.out0, got_r.out1, exp_r.out0, exp_r.out1));
		end
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic check_reset_state();
		assert (!weights_loaded && !busy && !result_valid && !pixel_full)
			else report_failure($sformatf("mismatch at %0t: outputs not idle after reset", $time));
		repeat (20) begin
			@(negedge clk);
			assert (!result_valid)
				else report_failure($sformatf("mismatch at %0t: result while idle", $time));
		end
	endtask

	// No weight set yet, so nothing is popped and the FIFO fills
	task automatic fill_before_load();
		for (int i = 0; i < `CONV_PIXEL_DEPTH; i++) begin
			write_pixel(pixel_t'($random(seed)));
		end
		stop_pixels();
		assert (pixel_full)
			else report_failure($sformatf("mismatch at %0t: pixel_full low after fill", $time));
		repeat (20) @(negedge clk);
		assert (got_q.size() == 0)
			else report_failure($sformatf("mismatch at %0t: result before weights", $time));
		load_weight_set(weight_t'($random(seed)), weight_t'($random(seed)),
			weight_t'($random(seed)), weight_t'($random(seed)));
		check_results(`CONV_PIXEL_DEPTH);
	endtask

	task automatic load_fixed_weights();
		load_weight_set(16'sd3, -16'sd2, 16'sd5, 16'sd7);
	endtask

	// Upper half is ch0
	task automatic fixed_pixels();
		write_pixel({16'sd10, -16'sd4});
		write_pixel({-16'sd1, 16'sd1});
		write_pixel({16'sd0, 16'sd0});
		write_pixel({16'sd1000, 16'sd2000});
		write_pixel({-16'sd300, -16'sd77});
		stop_pixels();
		check_results(5);
	endtask

	// Pixels enter from the start cycle on, held back while busy
	task automatic reload_with_queue();
		int cycles;
		write_weights(-16'sd1, 16'sd4, 16'sd9, -16'sd6);
		write_pixel({16'sd12, 16'sd34});
		start = 1'b1;
		write_pixel({-16'sd56, 16'sd78});
		start = 1'b0;
		write_pixel({16'sd90, -16'sd11});
		stop_pixels();
		assert (busy) else report_failure("busy did not rise after start");
		cycles = 0;
		while (busy) begin
			assert (!result_valid)
				else report_failure($sformatf("mismatch at %0t: result while busy", $time));
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				report_failure("timeout waiting for weight reload to finish");
			end
		end
		check_results(3);
	endtask

	// Two products of 2^30 each wrap to the most negative value
	task automatic extreme_operands();
		load_weight_set(16'sh8000, 16'sh8000, 16'sh8000, 16'sh8000);
		write_pixel({16'sh8000, 16'sh8000});
		stop_pixels();
		check_results(1);
	endtask

	initial begin
		int cycles;
		seed         = 82;
		loaded_seen  = 1'b0;
		weight_valid = 1'b0;
		weight_in    = '0;
		pixel_valid  = 1'b0;
		pixel_in     = '0;
		start        = 1'b0;
		cycles       = 0;
		while (reset !== 1'b0) begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT) begin
				report_failure("reset was never released");
			end
		end
		check_reset_state();
		fill_before_load();
		load_fixed_weights();
		fixed_pixels();
		reload_with_queue();
		extreme_operands();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+source
source/weight_pkg.sv
source/feature_pkg.sv
source/sync_fifo.sv
source/conv_1x1_weight_buffer.sv
source/conv_1x1_engine.sv
source/conv_1x1_top.sv
testbench/tb_clock_gen.sv
testbench/tb_conv_1x1_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the conv_1x1 testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module tb_conv_1x1_top -o sim_tb

# A failing run stops through $fatal, the log decides the outcome
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	echo "run_sim: simulation ok"
	exit 0
fi
echo "run_sim: simulation did not pass"
exit 1
